//--- Bender.yml
package:
  name: store_path

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/store_isa_pkg.sv
      - rtl/store_ctrl_pkg.sv
      - rtl/store_formatter.sv
      - rtl/store_fifo.sv
      - rtl/store_unit.sv
      - rtl/store_path.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clock_gen.sv
      - test/store_path_sva.sv
      - test/store_path_tb.sv

//--- list.f
+incdir+rtl
rtl/store_isa_pkg.sv
rtl/store_ctrl_pkg.sv
rtl/store_formatter.sv
rtl/store_fifo.sv
rtl/store_unit.sv
rtl/store_path.sv
test/tb_clock_gen.sv
test/store_path_sva.sv
test/store_path_tb.sv

//--- rtl/store_ctrl_pkg.sv
package store_ctrl_pkg;

    typedef enum logic [1:0] {
        fmt_empty = 2'h0,
        fmt_store = 2'h1,
        fmt_fence = 2'h2
    } fmt_state_e;

    typedef enum logic [1:0] {
        st_idle       = 2'h0,
        st_store_low  = 2'h1,
        st_store_high = 2'h2
    } store_state_e;

endpackage

//--- rtl/store_fifo.sv
`timescale 1ns/1ns
`include "store_settings.svh"

module store_fifo
    import store_isa_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         push,
    input  logic [`STORE_ADDR_WIDTH-1:0] push_addr,
    input  logic [`STORE_DATA_WIDTH-1:0] push_data,
    input  byte_en_t                     push_byte_enable,
    output logic                         full,
    output logic                         empty,
    output logic                         head_valid,
    output logic [`STORE_ADDR_WIDTH-1:0] head_addr,
    output logic [`STORE_DATA_WIDTH-1:0] head_data,
    output byte_en_t                     head_byte_enable,
    input  logic                         pop
);

    localparam int DEPTH = `STORE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`STORE_ADDR_WIDTH-1:0] addr_mem [DEPTH];
    logic [`STORE_DATA_WIDTH-1:0] data_mem [DEPTH];
    byte_en_t                     byte_enable_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign head_valid = !empty;

    // Head entry is read straight out of the array
    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];
    assign head_byte_enable = byte_enable_mem[rd_ptr];

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
            byte_enable_mem[wr_ptr] <= push_byte_enable;
        end
    end

endmodule

//--- rtl/store_formatter.sv
`timescale 1ns/1ns
`include "store_settings.svh"

module store_formatter
    import store_isa_pkg::*;
    import store_ctrl_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         store_valid,
    output logic                         store_ready,
    input  store_op_e                    store_op,
    input  logic [`STORE_ADDR_WIDTH-1:0] store_addr,
    input  logic [`STORE_DATA_WIDTH-1:0] store_data,
    output logic                         push,
    output logic [`STORE_ADDR_WIDTH-1:0] push_addr,
    output logic [`STORE_DATA_WIDTH-1:0] push_data,
    output byte_en_t                     push_byte_enable,
    input  logic                         full,
    input  logic                         fifo_empty,
    input  logic                         busy
);

    localparam int DW = `STORE_DATA_WIDTH;

    fmt_state_e     state;
    fmt_state_e     state_next;
    logic           accept;
    byte_en_t       byte_enable_in;
    logic [DW-1:0]  data_mask;

    assign store_ready = (state == fmt_empty);
    assign accept = store_valid && store_ready;
    assign push = (state == fmt_store) && !full;

    // Byte lanes and value mask by store size
    always_comb begin
        case (store_op)
            op_sb: begin
                byte_enable_in = byte_en_t'(4'b0001);
                data_mask = DW'(8'hff);
            end
            op_sh: begin
                byte_enable_in = byte_en_t'(4'b0011);
                data_mask = DW'(16'hffff);
            end
            op_sw: begin
                byte_enable_in = '1;
                data_mask = '1;
            end
            default: begin
                byte_enable_in = '0;
                data_mask = '0;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            fmt_empty: begin
                if (accept) begin
                    state_next = (store_op == op_fence) ? fmt_fence : fmt_store;
                end
            end
            fmt_store: begin
                if (!full) begin
                    state_next = fmt_empty;
                end
            end
            // Wait until nothing older is queued or in flight
            fmt_fence: begin
                if (fifo_empty && !busy) begin
                    state_next = fmt_empty;
                end
            end
            default: state_next = fmt_empty;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= fmt_empty;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && store_op != op_fence) begin
            push_addr <= store_addr;
            push_data <= store_data & data_mask;
            push_byte_enable <= byte_enable_in;
        end
    end

endmodule

//--- rtl/store_isa_pkg.sv
`include "store_settings.svh"

package store_isa_pkg;

    // Store port opcodes
    typedef enum logic [1:0] {
        op_sb    = 2'h0,
        op_sh    = 2'h1,
        op_sw    = 2'h2,
        op_fence = 2'h3
    } store_op_e;

    // One enable bit per byte lane of a data word
    typedef logic [`STORE_DATA_WIDTH/8-1:0] byte_en_t;

endpackage

//--- rtl/store_path.sv
`timescale 1ns/1ns
`include "store_settings.svh"

module store_path
    import store_isa_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         store_valid,
    output logic                         store_ready,
    input  store_op_e                    store_op,
    input  logic [`STORE_ADDR_WIDTH-1:0] store_addr,
    input  logic [`STORE_DATA_WIDTH-1:0] store_data,
    input  logic                         mem_ready,
    output logic                         mem_write_req,
    output logic [`STORE_ADDR_WIDTH-1:0] mem_addr,
    output logic [`STORE_DATA_WIDTH-1:0] mem_write_data,
    output byte_en_t                     mem_byte_enable
);

    // Formatter to FIFO
    logic                         push;
    logic [`STORE_ADDR_WIDTH-1:0] push_addr;
    logic [`STORE_DATA_WIDTH-1:0] push_data;
    byte_en_t                     push_byte_enable;
    logic                         full;
    logic                         fifo_empty;

    // FIFO to store unit
    logic                         head_valid;
    logic [`STORE_ADDR_WIDTH-1:0] head_addr;
    logic [`STORE_DATA_WIDTH-1:0] head_data;
    byte_en_t                     head_byte_enable;
    logic                         pop;
    logic                         busy;

    store_formatter formatter (
        .clk              (clk),
        .reset_n          (reset_n),
        .store_valid      (store_valid),
        .store_ready      (store_ready),
        .store_op         (store_op),
        .store_addr       (store_addr),
        .store_data       (store_data),
        .push             (push),
        .push_addr        (push_addr),
        .push_data        (push_data),
        .push_byte_enable (push_byte_enable),
        .full             (full),
        .fifo_empty       (fifo_empty),
        .busy             (busy)
    );

    store_fifo fifo (
        .clk              (clk),
        .reset_n          (reset_n),
        .push             (push),
        .push_addr        (push_addr),
        .push_data        (push_data),
        .push_byte_enable (push_byte_enable),
        .full             (full),
        .empty            (fifo_empty),
        .head_valid       (head_valid),
        .head_addr        (head_addr),
        .head_data        (head_data),
        .head_byte_enable (head_byte_enable),
        .pop              (pop)
    );

    store_unit unit (
        .clk              (clk),
        .reset_n          (reset_n),
        .head_valid       (head_valid),
        .head_addr        (head_addr),
        .head_data        (head_data),
        .head_byte_enable (head_byte_enable),
        .pop              (pop),
        .busy             (busy),
        .mem_ready        (mem_ready),
        .mem_write_req    (mem_write_req),
        .mem_addr         (mem_addr),
        .mem_write_data   (mem_write_data),
        .mem_byte_enable  (mem_byte_enable)
    );

endmodule

//--- rtl/store_settings.svh
`ifndef STORE_SETTINGS_SVH
`define STORE_SETTINGS_SVH

// FIFO depth in formatted stores (2 or more)
`define STORE_FIFO_DEPTH 4

// Byte address and store data widths
`define STORE_ADDR_WIDTH 32
`define STORE_DATA_WIDTH 32

`endif

//--- rtl/store_unit.sv
`timescale 1ns/1ns
`include "store_settings.svh"

module store_unit
    import store_isa_pkg::*;
    import store_ctrl_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         head_valid,
    input  logic [`STORE_ADDR_WIDTH-1:0] head_addr,
    input  logic [`STORE_DATA_WIDTH-1:0] head_data,
    input  byte_en_t                     head_byte_enable,
    output logic                         pop,
    output logic                         busy,
    input  logic                         mem_ready,
    output logic                         mem_write_req,
    output logic [`STORE_ADDR_WIDTH-1:0] mem_addr,
    output logic [`STORE_DATA_WIDTH-1:0] mem_write_data,
    output byte_en_t                     mem_byte_enable
);

    localparam int AW = `STORE_ADDR_WIDTH;
    localparam int DW = `STORE_DATA_WIDTH;
    localparam int BE = DW / 8;
    localparam int OFF = $clog2(BE);

    store_state_e state;
    store_state_e state_next;

    logic          mem_write_req_next;
    logic [AW-1:0] mem_addr_next;
    logic [DW-1:0] mem_write_data_next;
    byte_en_t      mem_byte_enable_next;

    // Store value and enables placed across two adjacent words
    logic [2*DW-1:0] write_word;
    logic [2*DW-1:0] write_word_next;
    logic [2*BE-1:0] write_word_byte_enable;
    logic [2*BE-1:0] write_word_byte_enable_next;

    logic [2*DW-1:0] shifted_data;
    logic [2*BE-1:0] shifted_byte_enable;
    logic [OFF-1:0]  byte_offset;

    assign byte_offset = head_addr[OFF-1:0];
    assign shifted_data = {{DW{1'b0}}, head_data} << {byte_offset, 3'b000};
    assign shifted_byte_enable = {{BE{1'b0}}, head_byte_enable} << byte_offset;

    assign pop = (state == st_idle) && head_valid;
    assign busy = (state != st_idle);

    always_comb begin
        state_next = state;
        mem_write_req_next = mem_write_req;
        mem_addr_next = mem_addr;
        mem_write_data_next = mem_write_data;
        mem_byte_enable_next = mem_byte_enable;
        write_word_next = write_word;
        write_word_byte_enable_next = write_word_byte_enable;

        case (state)
            st_idle: begin
                if (head_valid) begin
                    write_word_next = shifted_data;
                    write_word_byte_enable_next = shifted_byte_enable;

                    mem_addr_next = {head_addr[AW-1:OFF], {OFF{1'b0}}};
                    mem_write_data_next = shifted_data[DW-1:0];
                    mem_byte_enable_next = shifted_byte_enable[BE-1:0];
                    mem_write_req_next = 1'b1;

                    state_next = st_store_low;
                end
            end

            st_store_low: begin
                if (mem_ready) begin
                    if (write_word_byte_enable[2*BE-1:BE] == '0) begin
                        mem_write_req_next = 1'b0;
                        state_next = st_idle;
                    end else begin
                        // Spill into the following word
                        mem_addr_next = {mem_addr[AW-1:OFF] + 1'b1, {OFF{1'b0}}};
                        mem_write_data_next = write_word[2*DW-1:DW];
                        mem_byte_enable_next = write_word_byte_enable[2*BE-1:BE];
                        state_next = st_store_high;
                    end
                end
            end

            st_store_high: begin
                if (mem_ready) begin
                    mem_write_req_next = 1'b0;
                    state_next = st_idle;
                end
            end

            default: begin
                mem_write_req_next = 1'b0;
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            mem_write_req <= 1'b0;
        end else begin
            state <= state_next;
            mem_write_req <= mem_write_req_next;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr <= mem_addr_next;
        mem_write_data <= mem_write_data_next;
        mem_byte_enable <= mem_byte_enable_next;
        write_word <= write_word_next;
        write_word_byte_enable <= write_word_byte_enable_next;
    end

endmodule

//--- test/store_path_sva.sv
`timescale 1ns/1ns
`include "store_settings.svh"

module store_path_sva (
    input logic                           clk,
    input logic                           reset_n,
    input logic                           store_ready,
    input logic                           mem_ready,
    input logic                           mem_write_req,
    input logic [`STORE_ADDR_WIDTH-1:0]   mem_addr,
    input logic [`STORE_DATA_WIDTH-1:0]   mem_write_data,
    input logic [`STORE_DATA_WIDTH/8-1:0] mem_byte_enable
);

    // Count of failed assertions
    int error_count = 0;

    idle_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |-> !mem_write_req && store_ready)
        else begin
            $error("store path not idle when reset is released");
            error_count++;
        end

    beat_shape: assert property (@(posedge clk) disable iff (!reset_n)
        mem_write_req |-> mem_addr[1:0] == 2'b00 && mem_byte_enable != '0)
        else begin
            $error("memory beat is unaligned or has no byte enabled");
            error_count++;
        end

    held_while_waiting: assert property (@(posedge clk) disable iff (!reset_n)
        mem_write_req && !mem_ready |=> mem_write_req && $stable(mem_addr)
            && $stable(mem_write_data) && $stable(mem_byte_enable))
        else begin
            $error("memory request changed while waiting for mem_ready");
            error_count++;
        end

    // A beat directly after a completed one is the high word of a split store
    second_beat_addr: assert property (@(posedge clk) disable iff (!reset_n)
        mem_write_req && mem_ready ##1 mem_write_req |-> mem_addr == $past(mem_addr) + 4)
        else begin
            $error("second beat of a split store is not at the next word");
            error_count++;
        end

endmodule

bind store_path store_path_sva store_checks (.*);

//--- test/store_path_tb.sv
`timescale 1ns/1ns
`include "store_settings.svh"

module store_path_tb
    import store_isa_pkg::*;
();

    localparam int DEPTH = `STORE_FIFO_DEPTH;
    localparam int NUM_OPS = 24 + 24 + DEPTH + 3 + 21;

    logic        clk;
    logic        reset_n;
    logic        store_valid;
    logic        store_ready;
    store_op_e   store_op;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        mem_ready;
    logic        mem_write_req;
    logic [31:0] mem_addr;
    logic [31:0] mem_write_data;
    byte_en_t    mem_byte_enable;

    logic [7:0] mem_model [256];
    logic [7:0] ref_mem [256];
    int         beats_done;
    int         beats_expected;
    int         fence_beats;
    logic       fence_pending;
    logic       beat_fired;
    logic       stall_mem;
    string      test_name;

    tb_clock_gen clock_gen (.clk(clk), .reset_n(reset_n));

    store_path uut (.*);

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        stop_run("value mismatch");
    endtask

    task automatic send_store(input store_op_e op, input logic [31:0] addr,
                              input logic [31:0] data);
        logic taken;
        int   size;
        taken = 1'b0;
        size = (op == op_sb) ? 1 : (op == op_sh) ? 2 : (op == op_sw) ? 4 : 0;
        store_valid = 1'b1;
        store_op = op;
        store_addr = addr;
        store_data = data;
        while (!taken) begin
            taken = store_ready;
            @(posedge clk);
            #1;
        end
        store_valid = 1'b0;
        if (op == op_fence) begin
            fence_pending = 1'b1;
            fence_beats = beats_expected;
        end else begin
            if (fence_pending) begin
                assert (beats_done == fence_beats)
                    else report_mismatch("fence", fence_beats, beats_done);
                fence_pending = 1'b0;
            end
            // Byte k of the value lands at addr + k
            for (int k = 0; k < size; k++) begin
                ref_mem[8'(addr + k)] = data[8*k +: 8];
            end
            beats_expected += (int'(addr[1:0]) + size > 4) ? 2 : 1;
        end
    endtask

    task automatic check_memory();
        while (beats_done != beats_expected) begin
            @(posedge clk);
            #1;
        end
        for (int a = 0; a < 256; a++) begin
            assert (mem_model[a] === ref_mem[a])
                else report_mismatch(test_name, ref_mem[a], mem_model[a]);
        end
    endtask

    // Holds mem_ready low for 0 to 3 cycles per beat
    task automatic respond_memory();
        int delay;
        delay = $urandom_range(0, 3);
        forever begin
            @(posedge clk);
            #1;
            if (beat_fired) begin
                delay = $urandom_range(0, 3);
            end
            if (stall_mem || !mem_write_req) begin
                mem_ready = 1'b0;
            end else if (delay == 0) begin
                mem_ready = 1'b1;
            end else begin
                mem_ready = 1'b0;
                delay--;
            end
        end
    endtask

    always @(posedge clk) begin
        beat_fired = mem_write_req && mem_ready;
        if (beat_fired) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_byte_enable[k]) begin
                    mem_model[8'(mem_addr + k)] = mem_write_data[8*k +: 8];
                end
            end
            beats_done++;
        end
        if (store_checks_failed()) begin
            stop_run("a bound assertion on the store path failed");
        end
    end

    function automatic logic store_checks_failed();
        return uut.store_checks.error_count != 0;
    endfunction

    initial begin
        #((NUM_OPS * 20 + 1000) * 10);
        stop_run("timeout: the store path stopped making progress");
    end

    initial begin
        logic [31:0] addr;
        store_op_e   op;
        void'($urandom(32'hc88fb577));
        store_valid = 1'b0;
        store_op = op_sb;
        store_addr = '0;
        store_data = '0;
        mem_ready = 1'b0;
        stall_mem = 1'b0;
        fence_pending = 1'b0;
        beats_done = 0;
        beats_expected = 0;
        for (int a = 0; a < 256; a++) begin
            mem_model[a] = 8'(a * 37 + 11);
            ref_mem[a] = 8'(a * 37 + 11);
        end
        fork
            respond_memory();
        join_none
        @(posedge reset_n);
        @(posedge clk);
        #1;

        test_name = "aligned";
        repeat (24) begin
            op = store_op_e'($urandom_range(0, 2));
            addr = $urandom_range(0, 239);
            if (op == op_sh) addr[0] = 1'b0;
            if (op == op_sw) addr[1:0] = 2'b00;
            send_store(op, addr, $urandom());
        end
        check_memory();

        // Halfwords at offset 3 and words off the word boundary spill over
        test_name = "unaligned";
        repeat (24) begin
            op = ($urandom_range(0, 1) == 0) ? op_sh : op_sw;
            addr = $urandom_range(0, 239);
            addr[1:0] = (op == op_sh) ? 2'd3 : 2'($urandom_range(1, 3));
            send_store(op, addr, $urandom());
        end
        check_memory();

        test_name = "full path";
        stall_mem = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        for (int i = 0; i < DEPTH + 2; i++) begin
            send_store(store_op_e'(i % 3), 32'h80 + i % 5, $urandom());
        end
        store_valid = 1'b1;
        store_op = op_sw;
        store_addr = 32'h84;
        repeat (20) begin
            assert (!store_ready) else report_mismatch(test_name, 0, store_ready);
            @(posedge clk);
            #1;
        end
        stall_mem = 1'b0;
        send_store(op_sw, 32'h84, $urandom());
        check_memory();

        test_name = "fence";
        repeat (3) begin
            repeat (4) send_store(store_op_e'($urandom_range(0, 2)), $urandom_range(0, 239),
                                  $urandom());
            send_store(op_fence, '0, '0);
            repeat (2) send_store(store_op_e'($urandom_range(0, 2)), $urandom_range(0, 239),
                                  $urandom());
        end
        check_memory();

        if (store_checks_failed()) begin
            stop_run("a bound assertion on the store path failed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge so the first active edge sees a clean rise
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule
